//--- include/mem_settings.svh
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Data word and cache line widths
`define XLEN                32
`define LINE_WIDTH          128
`define LINE_WORDS          (`LINE_WIDTH / `XLEN)

// Byte address space of main memory
`define MEM_ADDR_WIDTH      16
`define MEM_WORDS           (2 ** (`MEM_ADDR_WIDTH - 2))

// Offsets inside a line: 16 bytes, 4 words
`define LINE_OFFSET_WIDTH   4
`define WORD_OFFSET_WIDTH   2

// Cache geometry, line count is a power of two
`define DCACHE_LINES        16
`define DCACHE_INDEX_WIDTH  ($clog2(`DCACHE_LINES))
`define DCACHE_TAG_WIDTH    (`MEM_ADDR_WIDTH - `DCACHE_INDEX_WIDTH - `LINE_OFFSET_WIDTH)

`endif

//--- source/mem_pkg.sv
`default_nettype none

`include "mem_settings.svh"

package mem_pkg;

    typedef logic [`MEM_ADDR_WIDTH-1:0]   addr_t;
    typedef logic [`XLEN-1:0]             word_t;
    typedef logic [`LINE_WIDTH-1:0]       line_t;
    typedef logic [3:0]                   sel_t;
    typedef logic [`DCACHE_TAG_WIDTH-1:0] tag_t;

    // Load/store unit request into the data cache
    typedef struct packed {
        logic  req;
        logic  w_en;
        sel_t  sel_byte;
        addr_t addr;
        word_t w_data;
    } type_lsu2dcache_s;

    typedef struct packed {
        logic  ack;
        word_t r_data;
    } type_dcache2lsu_s;

    // Line transfer request, addr is line aligned
    typedef struct packed {
        logic  req;
        logic  w_en;
        addr_t addr;
        line_t w_data;
    } type_cache2mem_s;

    typedef struct packed {
        logic  ack;
        line_t r_data;
    } type_mem2cache_s;

    // Cache controller states
    typedef enum logic [1:0] {
        idle,
        write_back,
        refill,
        respond
    } dcache_state_e;

endpackage : mem_pkg

`default_nettype wire

//--- source/main_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module main_mem
    import mem_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  type_cache2mem_s cache2mem,
    output type_mem2cache_s mem2cache
);

    // Word-wide storage that starts all zero
    word_t mem_words [`MEM_WORDS] = '{default: '0};

    // Line number that each word offset is appended to
    logic [`MEM_ADDR_WIDTH-`LINE_OFFSET_WIDTH-1:0] line_num;
    logic                                          accept;

    assign line_num = cache2mem.addr[`MEM_ADDR_WIDTH-1:`LINE_OFFSET_WIDTH];

    // A request is taken only when no acknowledge is pending
    assign accept = cache2mem.req & ~mem2cache.ack;

    // Line write into the word array
    always_ff @(posedge clk) begin
        if (accept && cache2mem.w_en) begin
            for (int w = 0; w < `LINE_WORDS; w++) begin
                mem_words[{line_num, `WORD_OFFSET_WIDTH'(w)}] <=
                    cache2mem.w_data[w*`XLEN +: `XLEN];
            end
        end
    end

    // Response register holding the read line and a single cycle acknowledge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem2cache <= '0;
        end else if (accept) begin
            if (cache2mem.w_en) begin
                mem2cache.r_data <= '0;
            end else begin
                for (int w = 0; w < `LINE_WORDS; w++) begin
                    mem2cache.r_data[w*`XLEN +: `XLEN] <=
                        mem_words[{line_num, `WORD_OFFSET_WIDTH'(w)}];
                end
            end
            mem2cache.ack <= 1'b1;
        end else begin
            // Idle or just acknowledged
            mem2cache <= '0;
        end
    end

    // Requests arrive line aligned as the offset bits are dropped
    line_aligned_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        cache2mem.req |-> cache2mem.addr[`LINE_OFFSET_WIDTH-1:0] == '0
    ) else $error("main_mem: request address not line aligned");

endmodule : main_mem

`default_nettype wire

//--- source/dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module dcache
    import mem_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  type_lsu2dcache_s lsu2dcache,
    output type_dcache2lsu_s dcache2lsu,
    output type_cache2mem_s  cache2mem,
    input  type_mem2cache_s  mem2cache
);

    // Line storage and per-line tag, valid and dirty
    line_t                    lines [`DCACHE_LINES];
    tag_t                     tags  [`DCACHE_LINES];
    logic [`DCACHE_LINES-1:0] valid;
    logic [`DCACHE_LINES-1:0] dirty;

    dcache_state_e state;
    dcache_state_e state_next;

    // Fields of the current core address
    tag_t                           req_tag;
    logic [`DCACHE_INDEX_WIDTH-1:0] index;
    logic [`WORD_OFFSET_WIDTH-1:0]  word_off;

    line_t cur_line;
    word_t cur_word;
    word_t merged_word;
    line_t merged_line;
    logic  hit;
    logic  victim_dirty;
    logic  refill_done;
    logic  store_done;

    assign req_tag  = lsu2dcache.addr[`MEM_ADDR_WIDTH-1 -: `DCACHE_TAG_WIDTH];
    assign index    = lsu2dcache.addr[`LINE_OFFSET_WIDTH +: `DCACHE_INDEX_WIDTH];
    assign word_off = lsu2dcache.addr[`LINE_OFFSET_WIDTH-1 -: `WORD_OFFSET_WIDTH];

    // Selected line and word
    assign cur_line = lines[index];
    assign cur_word = cur_line[word_off*`XLEN +: `XLEN];

    assign hit          = valid[index] && (tags[index] == req_tag);
    assign victim_dirty = valid[index] && dirty[index];

    assign refill_done = (state == refill) && mem2cache.ack;
    assign store_done  = (state == respond) && lsu2dcache.w_en;

    // Byte merge of the store data into the addressed word
    always_comb begin
        merged_word = cur_word;
        for (int b = 0; b < `XLEN / 8; b++) begin
            if (lsu2dcache.sel_byte[b]) begin
                merged_word[b*8 +: 8] = lsu2dcache.w_data[b*8 +: 8];
            end
        end
    end

    always_comb begin
        merged_line = cur_line;
        merged_line[word_off*`XLEN +: `XLEN] = merged_word;
    end

    // Controller next state
    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (lsu2dcache.req) begin
                    if (hit) begin
                        state_next = respond;
                    end else if (victim_dirty) begin
                        state_next = write_back;
                    end else begin
                        state_next = refill;
                    end
                end
            end
            write_back: begin
                // Victim line accepted by memory, fetch the new one
                if (mem2cache.ack) begin
                    state_next = refill;
                end
            end
            refill: begin
                if (mem2cache.ack) begin
                    state_next = respond;
                end
            end
            respond: begin
                state_next = idle;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    // Control state: FSM, valid and dirty bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
            valid <= '0;
            dirty <= '0;
        end else begin
            state <= state_next;
            if (refill_done) begin
                valid[index] <= 1'b1;
                dirty[index] <= 1'b0;
            end
            if (store_done) begin
                dirty[index] <= 1'b1;
            end
        end
    end

    // Line and tag arrays
    always_ff @(posedge clk) begin
        if (refill_done) begin
            lines[index] <= mem2cache.r_data;
            tags[index]  <= req_tag;
        end else if (store_done) begin
            lines[index] <= merged_line;
        end
    end

    // Memory side request, held by the state until memory acks
    always_comb begin
        cache2mem = '0;
        case (state)
            write_back: begin
                cache2mem.req    = 1'b1;
                cache2mem.w_en   = 1'b1;
                // Victim address rebuilt from the stored tag
                cache2mem.addr   = {tags[index], index, {`LINE_OFFSET_WIDTH{1'b0}}};
                cache2mem.w_data = cur_line;
            end
            refill: begin
                cache2mem.req  = 1'b1;
                cache2mem.addr = {req_tag, index, {`LINE_OFFSET_WIDTH{1'b0}}};
            end
            default: begin
                cache2mem.req = 1'b0;
            end
        endcase
    end

    // Core response is produced in respond only, for hits and misses alike
    always_comb begin
        dcache2lsu.ack    = (state == respond);
        dcache2lsu.r_data = (state == respond) ? cur_word : '0;
    end

    // Memory request must not move before it is answered
    mem_req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        cache2mem.req && !mem2cache.ack |=>
            cache2mem.req && $stable(cache2mem.addr) && $stable(cache2mem.w_en)
    ) else $error("dcache: memory request changed before ack");

    // No answer without a pending core request
    core_ack_with_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        dcache2lsu.ack |-> lsu2dcache.req
    ) else $error("dcache: core ack without core request");

endmodule : dcache

`default_nettype wire

//--- source/mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem
    import mem_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  type_lsu2dcache_s lsu2dcache,
    output type_dcache2lsu_s dcache2lsu
);

    // Line traffic between cache and memory
    type_cache2mem_s cache2mem;
    type_mem2cache_s mem2cache;

    dcache u_dcache (
        .clk        (clk),
        .rst_n      (rst_n),
        .lsu2dcache (lsu2dcache),
        .dcache2lsu (dcache2lsu),
        .cache2mem  (cache2mem),
        .mem2cache  (mem2cache)
    );

    // Fixed one cycle latency backing store
    main_mem u_main_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .cache2mem (cache2mem),
        .mem2cache (mem2cache)
    );

endmodule : mem_subsystem

`default_nettype wire

//--- verification/mem_subsystem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_settings.svh"

module mem_subsystem_tb
    import mem_pkg::*;
();

    localparam int CLK_PERIOD         = 8;
    localparam int RESET_CYCLES       = 3;
    localparam int HIT_LATENCY        = 1;
    localparam int CLEAN_MISS_LATENCY = 3;
    localparam int DIRTY_MISS_LATENCY = 5;
    localparam int NUM_DIRECTED       = 20;
    localparam int NUM_RANDOM         = 400;
    // Each access costs at most a dirty miss plus the gap cycle after its ack
    localparam int TIMEOUT_NS =
        (NUM_DIRECTED + NUM_RANDOM) * (DIRTY_MISS_LATENCY + 2) * CLK_PERIOD
        + 100 * CLK_PERIOD;

    // Stride to the same index with the next tag
    localparam addr_t ALIAS_STRIDE = addr_t'(`DCACHE_LINES * 16);
    localparam addr_t RANDOM_BASE  = 16'h4000;

    logic             clk = 1'b0;
    logic             rst_n;
    type_lsu2dcache_s lsu2dcache;
    type_dcache2lsu_s dcache2lsu;

    // Reference memory and a shadow of the cache tags
    word_t                    ref_words [`MEM_WORDS];
    tag_t                     model_tag [`DCACHE_LINES];
    logic [`DCACHE_LINES-1:0] model_valid;
    logic [`DCACHE_LINES-1:0] model_dirty;

    string       test_name;
    word_t       exp_data;
    int          exp_latency;
    int          req_cycles;
    logic [31:0] rng_state;
    int          data_errors;
    int          latency_errors;
    int          protocol_errors;

    mem_subsystem dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .lsu2dcache (lsu2dcache),
        .dcache2lsu (dcache2lsu)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Edges with the request up and not yet answered
    always @(posedge clk) begin
        if (!rst_n || !lsu2dcache.req || dcache2lsu.ack) begin
            req_cycles <= 0;
        end else begin
            req_cycles <= req_cycles + 1;
        end
    end

    read_data_check: assert property (
        @(posedge clk) disable iff (!rst_n)
        dcache2lsu.ack && !lsu2dcache.w_en |-> dcache2lsu.r_data == exp_data
    ) else begin
        data_errors++;
        $display("Mismatch %s: expected %h, actual %h",
                 test_name, exp_data, $sampled(dcache2lsu.r_data));
    end

    latency_check: assert property (
        @(posedge clk) disable iff (!rst_n)
        dcache2lsu.ack |-> req_cycles == exp_latency
    ) else begin
        latency_errors++;
        $display("Mismatch %s latency: expected %0d, actual %0d",
                 test_name, exp_latency, $sampled(req_cycles));
    end

    ack_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        dcache2lsu.ack |-> lsu2dcache.req
    ) else begin
        protocol_errors++;
        $display("Core ack raised without a pending request in test %s", test_name);
    end

    ack_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n)
        dcache2lsu.ack |=> !dcache2lsu.ack
    ) else begin
        protocol_errors++;
        $display("Core ack stayed high for more than one cycle in test %s", test_name);
    end

    // No answer may come out of reset
    quiet_after_reset: assert property (
        @(posedge clk) !rst_n |=> !dcache2lsu.ack
    ) else begin
        protocol_errors++;
        $display("Core ack high right after reset");
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Only the strobed bytes take the new data
    function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                          input sel_t sel);
        word_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    // Word address from four tags that share each index
    function automatic addr_t alias_addr(input logic [31:0] r);
        addr_t a;
        a = RANDOM_BASE;
        a = a + addr_t'(r[1:0]) * ALIAS_STRIDE;
        a = a + (addr_t'(r[15:8]) % addr_t'(`DCACHE_LINES)) * addr_t'(16);
        a = a + addr_t'(r[7:6]) * addr_t'(4);
        return a;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // One core access that starts and ends on a falling edge
    task automatic access(input logic w_en, input addr_t addr, input word_t data,
                          input sel_t sel);
        logic [`DCACHE_INDEX_WIDTH-1:0] idx;
        tag_t                           tag;
        int                             waddr;
        logic                           hit;
        idx   = addr[`LINE_OFFSET_WIDTH +: `DCACHE_INDEX_WIDTH];
        tag   = addr[`MEM_ADDR_WIDTH-1 -: `DCACHE_TAG_WIDTH];
        waddr = int'(addr[`MEM_ADDR_WIDTH-1:2]);
        hit   = model_valid[idx] && (model_tag[idx] == tag);
        if (hit) begin
            exp_latency = HIT_LATENCY;
        end else if (model_valid[idx] && model_dirty[idx]) begin
            exp_latency = DIRTY_MISS_LATENCY;
        end else begin
            exp_latency = CLEAN_MISS_LATENCY;
        end
        exp_data = ref_words[waddr];

        lsu2dcache.req      = 1'b1;
        lsu2dcache.w_en     = w_en;
        lsu2dcache.sel_byte = sel;
        lsu2dcache.addr     = addr;
        lsu2dcache.w_data   = data;

        @(negedge clk);
        while (!dcache2lsu.ack) begin
            @(negedge clk);
        end

        if (!hit) begin
            model_valid[idx] = 1'b1;
            model_tag[idx]   = tag;
            model_dirty[idx] = 1'b0;
        end
        if (w_en) begin
            model_dirty[idx] = 1'b1;
            ref_words[waddr] = merge_bytes(ref_words[waddr], data, sel);
        end

        // Fields stay held through the ack edge and drop one cycle later
        @(negedge clk);
        lsu2dcache.req = 1'b0;
    endtask

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout after %0d ns, the DUT stopped answering in test %s",
                 TIMEOUT_NS, test_name);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        addr_t addr;
        logic  is_write;
        sel_t  sel;
        lsu2dcache      = '0;
        rst_n           = 1'b0;
        rng_state       = 32'd97340;
        data_errors     = 0;
        latency_errors  = 0;
        protocol_errors = 0;
        exp_data        = '0;
        exp_latency     = 0;
        test_name       = "reset_idle";
        model_valid     = '0;
        model_dirty     = '0;
        for (int i = 0; i < `DCACHE_LINES; i++) begin
            model_tag[i] = '0;
        end
        for (int i = 0; i < `MEM_WORDS; i++) begin
            ref_words[i] = '0;
        end

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // No request means no ack
        idle_cycles(6);
        // Untouched memory reads zero
        access(1'b0, 16'h0000, '0, 4'hf);
        access(1'b0, 16'h1234, '0, 4'hf);
        access(1'b0, 16'hfffc, '0, 4'hf);

        test_name = "write_read_hit";
        access(1'b1, 16'h0100, 32'hdeadbeef, 4'hf);
        access(1'b0, 16'h0100, '0, 4'hf);
        access(1'b1, 16'h0100, 32'h11223344, 4'b0101);
        access(1'b0, 16'h0100, '0, 4'hf);
        access(1'b1, 16'h0108, 32'ha5a5a5a5, 4'b1000);
        access(1'b0, 16'h0108, '0, 4'hf);

        test_name = "eviction";
        access(1'b1, 16'h0520, 32'hcafe0001, 4'hf);
        access(1'b0, 16'h0520 + ALIAS_STRIDE, '0, 4'hf);
        access(1'b0, 16'h0520, '0, 4'hf);
        access(1'b1, 16'h0520 + ALIAS_STRIDE, 32'h0badf00d, 4'hf);
        access(1'b0, 16'h0520, '0, 4'hf);
        access(1'b0, 16'h0520 + ALIAS_STRIDE, '0, 4'hf);

        test_name = "miss_latency";
        access(1'b1, 16'h0a70, 32'h76543210, 4'b0011);
        access(1'b0, 16'h0a74, '0, 4'hf);
        access(1'b0, 16'h0a70 + ALIAS_STRIDE, '0, 4'hf);
        access(1'b0, 16'h0a70 + ALIAS_STRIDE, '0, 4'hf);
        access(1'b0, 16'h0a70, '0, 4'hf);

        test_name = "random_mix";
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rng_state = xorshift32(rng_state);
            addr      = alias_addr(rng_state);
            is_write  = rng_state[20];
            sel       = sel_t'(rng_state[27:24]);
            if (sel == '0) begin
                sel = 4'hf;
            end
            rng_state = xorshift32(rng_state);
            access(is_write, addr, rng_state, sel);
        end

        idle_cycles(4);
        $display("Errors: data %0d, latency %0d, protocol %0d",
                 data_errors, latency_errors, protocol_errors);
        if (data_errors + latency_errors + protocol_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : mem_subsystem_tb

`default_nettype wire

//--- sources.f
+incdir+include
source/mem_pkg.sv
source/main_mem.sv
source/dcache.sv
source/mem_subsystem.sv
verification/mem_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f \
    --top-module mem_subsystem_tb --Mdir build -o mem_subsystem_sim

./build/mem_subsystem_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
